/* hdl/mv_pkg.sv */
// Shared word types and width constants of the matrix-vector engine, referenced by scoped names
package mv_pkg;

  // ####################################################################
  // Widths
  // ####################################################################

  // Input elements are signed 16-bit words
  localparam int unsigned DATA_W = 16;

  // Wide enough for 32-bit products summed over up to 256 columns
  localparam int unsigned ACC_W  = 40;

  // Plain vectors; arithmetic treats them as signed
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [ACC_W-1:0]  acc_t;

  // Index width for a counter over n entries, at least one bit
  function automatic int unsigned idx_w(int unsigned n);
    return (n > 1) ? $clog2(n) : 1;
  endfunction

endpackage

/* hdl/mv_mac_lane.sv */
// One signed multiply-accumulate lane; the top level builds one per matrix row
`timescale 1ns/100ps

module mv_mac_lane (
  input  logic          clk_i,
  input  logic          rst_ni,
  input  logic          clear_i,
  input  logic          valid_i,
  input  logic          first_i,
  input  mv_pkg::data_t x_i,
  input  mv_pkg::data_t w_i,
  output mv_pkg::acc_t  acc_o
);

  logic signed [2*mv_pkg::DATA_W-1:0] prod;
  mv_pkg::acc_t                       prod_ext;
  mv_pkg::acc_t                       acc_q;

  assign prod     = $signed(x_i) * $signed(w_i);
  assign prod_ext = {{(mv_pkg::ACC_W - 2*mv_pkg::DATA_W){prod[2*mv_pkg::DATA_W-1]}}, prod};

  // The first column of a job starts a fresh sum
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      acc_q <= '0;
    end else if (clear_i) begin
      acc_q <= '0;
    end else if (valid_i) begin
      if (first_i) begin
        acc_q <= prod_ext;
      end else begin
        acc_q <= acc_q + prod_ext;
      end
    end
  end

  assign acc_o = acc_q;

endmodule

/* hdl/mv_transpose_buf.sv */
// Operand buffer written one matrix row at a time and read back one column per cycle
`timescale 1ns/100ps

module mv_transpose_buf #(
  parameter  int unsigned ROWS = 4,
  parameter  int unsigned COLS = 4,
  localparam int unsigned RW   = mv_pkg::idx_w(ROWS),
  localparam int unsigned CW   = mv_pkg::idx_w(COLS)
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     clear_i,
  input  logic                     write_en_i,
  input  logic [RW-1:0]            write_addr_i,
  input  mv_pkg::data_t [COLS-1:0] wdata_i,
  input  logic                     read_en_i,
  input  logic [CW-1:0]            read_addr_i,
  output mv_pkg::data_t [ROWS-1:0] rdata_o
);

  mv_pkg::data_t [ROWS-1:0][COLS-1:0] buffer_q;
  logic [CW-1:0]                      read_addr_q;

  // Column select is registered, which gives the read its one-cycle latency
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      read_addr_q <= '0;
    end else if (clear_i) begin
      read_addr_q <= '0;
    end else if (read_en_i) begin
      read_addr_q <= read_addr_i;
    end
  end

  // ####################################################################
  // Storage
  // ####################################################################

  for (genvar r = 0; r < ROWS; r++) begin : gen_rows
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        buffer_q[r] <= '0;
      end else if (clear_i) begin
        buffer_q[r] <= '0;
      end else if (write_en_i && write_addr_i == RW'(r)) begin
        buffer_q[r] <= wdata_i;
      end
    end

    // Element r of the selected column
    assign rdata_o[r] = buffer_q[r][read_addr_q];
  end

endmodule

/* hdl/mv_feeder.sv */
// Input sequencer: takes the job word stream, writes matrix rows to the buffer and runs the columns
`timescale 1ns/100ps

module mv_feeder #(
  parameter  int unsigned ROWS = 4,
  parameter  int unsigned COLS = 4,
  localparam int unsigned RW   = mv_pkg::idx_w(ROWS),
  localparam int unsigned CW   = mv_pkg::idx_w(COLS)
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     clear_i,
  input  logic                     in_req_i,
  input  mv_pkg::data_t            in_data_i,
  output logic                     in_ack_o,
  output logic                     wr_en_o,
  output logic [RW-1:0]            wr_row_o,
  output mv_pkg::data_t [COLS-1:0] wr_data_o,
  output logic                     rd_en_o,
  output logic [CW-1:0]            rd_col_o,
  output logic                     lane_valid_o,
  output logic                     lane_first_o,
  output mv_pkg::data_t            lane_weight_o,
  output logic                     job_done_o,
  input  logic                     drain_busy_i
);

  typedef enum logic [1:0] {
    ST_LOAD_X,
    ST_LOAD_W,
    ST_COMPUTE,
    ST_WAIT_DRAIN
  } state_e;

  state_e                   state_q;
  logic                     ack_q;
  logic                     accept;
  logic                     last_elem;
  logic [RW-1:0]            row_cnt_q;
  logic [CW-1:0]            elem_cnt_q;
  logic [CW-1:0]            col_cnt_q;
  mv_pkg::data_t [COLS-1:0] row_buf_q;
  mv_pkg::data_t [COLS-1:0] weight_q;
  logic                     wr_en_q;
  logic [RW-1:0]            wr_row_q;
  logic                     lane_valid_q;
  logic                     lane_first_q;
  mv_pkg::data_t            lane_weight_q;

  // A word is taken only while loading and only at the start of a handshake
  assign accept    = in_req_i && !ack_q && (state_q == ST_LOAD_X || state_q == ST_LOAD_W);
  assign last_elem = (elem_cnt_q == CW'(COLS - 1));

  // ####################################################################
  // Input handshake
  // ####################################################################

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_q <= 1'b0;
    end else if (clear_i) begin
      ack_q <= 1'b0;
    end else if (accept) begin
      ack_q <= 1'b1;
    end else if (ack_q && !in_req_i) begin
      ack_q <= 1'b0;
    end
  end

  // Row assembly, weight file and the weight that goes with each column read
  always_ff @(posedge clk_i) begin
    if (accept && state_q == ST_LOAD_X) begin
      row_buf_q[elem_cnt_q] <= in_data_i;
    end
    if (accept && state_q == ST_LOAD_W) begin
      weight_q[elem_cnt_q] <= in_data_i;
    end
    if (state_q == ST_COMPUTE) begin
      lane_weight_q <= weight_q[col_cnt_q];
    end
  end

  // ####################################################################
  // Job sequencing
  // ####################################################################

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= ST_LOAD_X;
      row_cnt_q  <= '0;
      elem_cnt_q <= '0;
      col_cnt_q  <= '0;
    end else if (clear_i) begin
      state_q    <= ST_LOAD_X;
      row_cnt_q  <= '0;
      elem_cnt_q <= '0;
      col_cnt_q  <= '0;
    end else begin
      case (state_q)
        ST_LOAD_X: begin
          if (accept && last_elem) begin
            elem_cnt_q <= '0;
            if (row_cnt_q == RW'(ROWS - 1)) begin
              row_cnt_q <= '0;
              state_q   <= ST_LOAD_W;
            end else begin
              row_cnt_q <= row_cnt_q + 1'b1;
            end
          end else if (accept) begin
            elem_cnt_q <= elem_cnt_q + 1'b1;
          end
        end
        ST_LOAD_W: begin
          if (accept && last_elem) begin
            elem_cnt_q <= '0;
            col_cnt_q  <= '0;
            state_q    <= ST_COMPUTE;
          end else if (accept) begin
            elem_cnt_q <= elem_cnt_q + 1'b1;
          end
        end
        ST_COMPUTE: begin
          if (col_cnt_q == CW'(COLS - 1)) begin
            col_cnt_q <= '0;
            state_q   <= ST_WAIT_DRAIN;
          end else begin
            col_cnt_q <= col_cnt_q + 1'b1;
          end
        end
        ST_WAIT_DRAIN: begin
          if (job_done_o) begin
            state_q <= ST_LOAD_X;
          end
        end
        default: state_q <= ST_LOAD_X;
      endcase
    end
  end

  // Row write and lane controls trail their cause by one cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_en_q      <= 1'b0;
      wr_row_q     <= '0;
      lane_valid_q <= 1'b0;
      lane_first_q <= 1'b0;
    end else if (clear_i) begin
      wr_en_q      <= 1'b0;
      wr_row_q     <= '0;
      lane_valid_q <= 1'b0;
      lane_first_q <= 1'b0;
    end else begin
      wr_en_q      <= accept && (state_q == ST_LOAD_X) && last_elem;
      lane_valid_q <= rd_en_o;
      lane_first_q <= rd_en_o && (col_cnt_q == '0);
      if (accept && state_q == ST_LOAD_X) begin
        wr_row_q <= row_cnt_q;
      end
    end
  end

  assign in_ack_o      = ack_q;
  assign wr_en_o       = wr_en_q;
  assign wr_row_o      = wr_row_q;
  assign wr_data_o     = row_buf_q;
  assign rd_en_o       = (state_q == ST_COMPUTE);
  assign rd_col_o      = col_cnt_q;
  assign lane_valid_o  = lane_valid_q;
  assign lane_first_o  = lane_first_q;
  assign lane_weight_o = lane_weight_q;

  // Lanes settle one cycle after the last valid; hold here while the drain is still sending
  assign job_done_o    = (state_q == ST_WAIT_DRAIN) && !lane_valid_q && !drain_busy_i;

endmodule

/* hdl/mv_drain.sv */
// Result drain: captures all lane sums at job end and sends them out in row order by handshake
`timescale 1ns/100ps

module mv_drain #(
  parameter  int unsigned ROWS = 4,
  localparam int unsigned RW   = mv_pkg::idx_w(ROWS)
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    clear_i,
  input  logic                    job_done_i,
  input  mv_pkg::acc_t [ROWS-1:0] acc_i,
  output logic                    busy_o,
  output logic                    out_req_o,
  output mv_pkg::acc_t            out_data_o,
  input  logic                    out_ack_i
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_REQ,
    ST_RELEASE
  } state_e;

  state_e                  state_q;
  logic [RW-1:0]           idx_q;
  mv_pkg::acc_t [ROWS-1:0] hold_q;

  // Holding copy lets the lanes start on the next job right away
  always_ff @(posedge clk_i) begin
    if (state_q == ST_IDLE && job_done_i) begin
      hold_q <= acc_i;
    end
  end

  // ####################################################################
  // Output handshake
  // ####################################################################

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ST_IDLE;
      idx_q   <= '0;
    end else if (clear_i) begin
      state_q <= ST_IDLE;
      idx_q   <= '0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (job_done_i) begin
            idx_q   <= '0;
            state_q <= ST_REQ;
          end
        end
        ST_REQ: begin
          if (out_ack_i) begin
            state_q <= ST_RELEASE;
          end
        end
        ST_RELEASE: begin
          // Next word only once the sink has dropped its ack
          if (!out_ack_i) begin
            if (idx_q == RW'(ROWS - 1)) begin
              idx_q   <= '0;
              state_q <= ST_IDLE;
            end else begin
              idx_q   <= idx_q + 1'b1;
              state_q <= ST_REQ;
            end
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  assign busy_o     = (state_q != ST_IDLE);
  assign out_req_o  = (state_q == ST_REQ);
  assign out_data_o = hold_q[idx_q];

endmodule

/* hdl/mv_top.sv */
// Top level of the matrix-vector engine; connects feeder, buffer, lanes and drain
`timescale 1ns/100ps

module mv_top #(
  parameter  int unsigned ROWS = 4,
  parameter  int unsigned COLS = 4,
  localparam int unsigned RW   = mv_pkg::idx_w(ROWS),
  localparam int unsigned CW   = mv_pkg::idx_w(COLS)
) (
  input  logic          clk_i,
  input  logic          rst_ni,
  input  logic          clear_i,
  input  logic          in_req_i,
  input  mv_pkg::data_t in_data_i,
  output logic          in_ack_o,
  output logic          out_req_o,
  output mv_pkg::acc_t  out_data_o,
  input  logic          out_ack_i
);

  logic                     wr_en;
  logic [RW-1:0]            wr_row;
  mv_pkg::data_t [COLS-1:0] wr_data;
  logic                     rd_en;
  logic [CW-1:0]            rd_col;
  mv_pkg::data_t [ROWS-1:0] rd_data;
  logic                     lane_valid;
  logic                     lane_first;
  mv_pkg::data_t            lane_weight;
  mv_pkg::acc_t [ROWS-1:0]  lane_acc;
  logic                     job_done;
  logic                     drain_busy;

  mv_feeder #(
    .ROWS ( ROWS ),
    .COLS ( COLS )
  ) u_feeder (
    .clk_i         ( clk_i       ),
    .rst_ni        ( rst_ni      ),
    .clear_i       ( clear_i     ),
    .in_req_i      ( in_req_i    ),
    .in_data_i     ( in_data_i   ),
    .in_ack_o      ( in_ack_o    ),
    .wr_en_o       ( wr_en       ),
    .wr_row_o      ( wr_row      ),
    .wr_data_o     ( wr_data     ),
    .rd_en_o       ( rd_en       ),
    .rd_col_o      ( rd_col      ),
    .lane_valid_o  ( lane_valid  ),
    .lane_first_o  ( lane_first  ),
    .lane_weight_o ( lane_weight ),
    .job_done_o    ( job_done    ),
    .drain_busy_i  ( drain_busy  )
  );

  mv_transpose_buf #(
    .ROWS ( ROWS ),
    .COLS ( COLS )
  ) u_buf (
    .clk_i        ( clk_i   ),
    .rst_ni       ( rst_ni  ),
    .clear_i      ( clear_i ),
    .write_en_i   ( wr_en   ),
    .write_addr_i ( wr_row  ),
    .wdata_i      ( wr_data ),
    .read_en_i    ( rd_en   ),
    .read_addr_i  ( rd_col  ),
    .rdata_o      ( rd_data )
  );

  // ####################################################################
  // One lane per matrix row, all sharing the column weight
  // ####################################################################

  for (genvar r = 0; r < ROWS; r++) begin : gen_lanes
    mv_mac_lane u_lane (
      .clk_i   ( clk_i       ),
      .rst_ni  ( rst_ni      ),
      .clear_i ( clear_i     ),
      .valid_i ( lane_valid  ),
      .first_i ( lane_first  ),
      .x_i     ( rd_data[r]  ),
      .w_i     ( lane_weight ),
      .acc_o   ( lane_acc[r] )
    );
  end

  mv_drain #(
    .ROWS ( ROWS )
  ) u_drain (
    .clk_i      ( clk_i      ),
    .rst_ni     ( rst_ni     ),
    .clear_i    ( clear_i    ),
    .job_done_i ( job_done   ),
    .acc_i      ( lane_acc   ),
    .busy_o     ( drain_busy ),
    .out_req_o  ( out_req_o  ),
    .out_data_o ( out_data_o ),
    .out_ack_i  ( out_ack_i  )
  );

endmodule

/* test/tb_mv_top.sv */
// Self-checking testbench for mv_top; runs random, extreme, back-pressure and flush jobs
`timescale 1ns/100ps

module tb_mv_top;

  localparam int unsigned ROWS        = 3;
  localparam int unsigned COLS        = 5;
  localparam int unsigned WORDS       = ROWS * COLS + COLS;
  localparam int unsigned NUM_JOBS    = 15;
  // A word takes at most 8 cycles and a result at most 63 + 8 cycles
  localparam int unsigned JOB_CYC     = WORDS * 8 + ROWS * 71 + 40;
  localparam int unsigned WATCHDOG_NS = NUM_JOBS * JOB_CYC * 8 + 2000;

  logic          clk_i;
  logic          rst_ni;
  logic          clear_i;
  logic          in_req_i;
  mv_pkg::data_t in_data_i;
  logic          in_ack_o;
  logic          out_req_o;
  mv_pkg::acc_t  out_data_o;
  logic          out_ack_i;

  logic [31:0]   lfsr_q;
  mv_pkg::acc_t  exp_q[$];
  int            errors;
  int            checked;
  logic          in_req_prev;
  logic          in_ack_prev;
  logic          out_req_prev;
  logic          out_ack_prev;
  logic          clear_prev;
  mv_pkg::acc_t  out_data_prev;

  mv_top #(
    .ROWS ( ROWS ),
    .COLS ( COLS )
  ) DUT (
    .clk_i      ( clk_i      ),
    .rst_ni     ( rst_ni     ),
    .clear_i    ( clear_i    ),
    .in_req_i   ( in_req_i   ),
    .in_data_i  ( in_data_i  ),
    .in_ack_o   ( in_ack_o   ),
    .out_req_o  ( out_req_o  ),
    .out_data_o ( out_data_o ),
    .out_ack_i  ( out_ack_i  )
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
    $display("Errors found");
    $finish;
  end

  // ####################################################################
  // Random source
  // ####################################################################

  function automatic logic [31:0] lfsr_step(logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'hB4BCD35C) : (s >> 1);
  endfunction

  // One LFSR step for every bit taken
  function automatic logic [31:0] rand_bits(int unsigned n);
    logic [31:0] v;
    v = '0;
    for (int unsigned i = 0; i < n; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      v      = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  // ####################################################################
  // Handshake drivers and model
  // ####################################################################

  task automatic send_word(input mv_pkg::data_t w);
    repeat (rand_bits(2)) @(posedge clk_i);
    @(posedge clk_i);
    in_req_i  <= 1'b1;
    in_data_i <= w;
    @(posedge clk_i);
    while (!in_ack_o) @(posedge clk_i);
    in_req_i <= 1'b0;
    @(posedge clk_i);
    while (in_ack_o) @(posedge clk_i);
  endtask

  // Mode 0 is random, 1 is all most negative, 2 is alternating signs at full scale
  task automatic send_job(input int mode, input int unsigned n_words, input bit expect_out);
    mv_pkg::data_t x[ROWS][COLS];
    mv_pkg::data_t w[COLS];
    mv_pkg::data_t words[$];
    longint        sum;
    for (int unsigned r = 0; r < ROWS; r++) begin
      for (int unsigned c = 0; c < COLS; c++) begin
        case (mode)
          1:       x[r][c] = 16'h8000;
          2:       x[r][c] = ((r + c) % 2 == 1) ? 16'h7fff : 16'h8000;
          default: x[r][c] = mv_pkg::data_t'(rand_bits(mv_pkg::DATA_W));
        endcase
        words.push_back(x[r][c]);
      end
    end
    for (int unsigned c = 0; c < COLS; c++) begin
      case (mode)
        1:       w[c] = 16'h8000;
        2:       w[c] = (c % 2 == 1) ? 16'h8000 : 16'h7fff;
        default: w[c] = mv_pkg::data_t'(rand_bits(mv_pkg::DATA_W));
      endcase
      words.push_back(w[c]);
    end
    if (expect_out) begin
      for (int unsigned r = 0; r < ROWS; r++) begin
        sum = 0;
        for (int unsigned c = 0; c < COLS; c++) begin
          sum += longint'($signed(x[r][c])) * longint'($signed(w[c]));
        end
        exp_q.push_back(mv_pkg::acc_t'(sum));
      end
    end
    for (int unsigned i = 0; i < n_words; i++) begin
      send_word(words[i]);
    end
  endtask

  task automatic receive_result(input int unsigned delay_bits);
    mv_pkg::acc_t want;
    @(posedge clk_i);
    while (!out_req_o) @(posedge clk_i);
    if (exp_q.size() == 0) begin
      errors++;
      $display("Result %h arrived at %0t with no result outstanding", out_data_o, $time);
    end else begin
      want = exp_q.pop_front();
      checked++;
      assert (out_data_o == want) else begin
        errors++;
        $display("[FAIL] %0t out_data_o got %h expected %h", $time, out_data_o, want);
      end
    end
    repeat (rand_bits(delay_bits)) @(posedge clk_i);
    out_ack_i <= 1'b1;
    @(posedge clk_i);
    while (out_req_o) @(posedge clk_i);
    out_ack_i <= 1'b0;
  endtask

  task automatic run_jobs(input int mode, input int unsigned n_jobs, input int unsigned delay_bits);
    fork
      begin
        for (int unsigned j = 0; j < n_jobs; j++) send_job(mode, WORDS, 1'b1);
      end
      begin
        for (int unsigned k = 0; k < n_jobs * ROWS; k++) receive_result(delay_bits);
      end
    join
  endtask

  // The source gives up any open word together with the flush
  task automatic pulse_clear();
    @(posedge clk_i);
    clear_i <= 1'b1;
    @(posedge clk_i);
    clear_i  <= 1'b0;
    in_req_i <= 1'b0;
    exp_q.delete();
  endtask

  task automatic check_idle(input string when);
    @(posedge clk_i);
    assert (!in_ack_o && !out_req_o) else begin
      errors++;
      $display("Handshake outputs not low after %s at %0t", when, $time);
    end
  endtask

  task automatic check_quiet(input int unsigned cycles);
    repeat (cycles) begin
      @(posedge clk_i);
      assert (!out_req_o) else begin
        errors++;
        $display("Unexpected result request at %0t", $time);
      end
    end
  endtask

  // ####################################################################
  // Protocol monitor
  // ####################################################################

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      in_req_prev   <= 1'b0;
      in_ack_prev   <= 1'b0;
      out_req_prev  <= 1'b0;
      out_ack_prev  <= 1'b0;
      clear_prev    <= 1'b0;
      out_data_prev <= '0;
    end else begin
      if (in_ack_o && !in_ack_prev) begin
        assert (in_req_prev) else begin
          errors++;
          $display("in_ack_o rose without in_req_i high at %0t", $time);
        end
      end
      if (!in_ack_o && in_ack_prev) begin
        assert (!in_req_prev || clear_prev) else begin
          errors++;
          $display("in_ack_o fell while in_req_i was still high at %0t", $time);
        end
      end
      if (!out_req_o && out_req_prev) begin
        assert (out_ack_prev || clear_prev) else begin
          errors++;
          $display("out_req_o fell before out_ack_i was seen at %0t", $time);
        end
      end
      if (out_req_o && out_req_prev) begin
        assert (out_data_o == out_data_prev) else begin
          errors++;
          $display("[FAIL] %0t out_data_o got %h expected %h", $time, out_data_o, out_data_prev);
        end
      end
      if (clear_prev) begin
        assert (!in_ack_o && !out_req_o) else begin
          errors++;
          $display("Handshake outputs still high after a flush at %0t", $time);
        end
      end
      in_req_prev   <= in_req_i;
      in_ack_prev   <= in_ack_o;
      out_req_prev  <= out_req_o;
      out_ack_prev  <= out_ack_i;
      clear_prev    <= clear_i;
      out_data_prev <= out_data_o;
    end
  end

  initial begin
    lfsr_q    = 32'hab11;
    errors    = 0;
    checked   = 0;
    rst_ni    = 1'b0;
    clear_i   = 1'b0;
    in_req_i  = 1'b0;
    in_data_i = '0;
    out_ack_i = 1'b0;
    repeat (3) @(posedge clk_i);
    rst_ni <= 1'b1;
    check_idle("reset");

    run_jobs(0, 6, 2);
    run_jobs(1, 1, 2);
    run_jobs(2, 1, 2);

    // Slow sink, so later jobs load while the drain still holds results
    run_jobs(0, 3, 6);

    // Flush in the middle of the matrix while a word's ack is still high
    send_job(0, WORDS / 2, 1'b0);
    @(posedge clk_i);
    in_req_i  <= 1'b1;
    in_data_i <= mv_pkg::data_t'(rand_bits(mv_pkg::DATA_W));
    @(posedge clk_i);
    while (!in_ack_o) @(posedge clk_i);
    pulse_clear();
    check_idle("a flush during load");
    run_jobs(0, 1, 2);

    // Flush with the second result of the job waiting for its ack
    send_job(0, WORDS, 1'b1);
    receive_result(2);
    @(posedge clk_i);
    while (!out_req_o) @(posedge clk_i);
    pulse_clear();
    check_quiet(30);
    run_jobs(0, 1, 2);
    check_quiet(30);

    assert (exp_q.size() == 0) else begin
      errors++;
      $display("%0d expected results never arrived", exp_q.size());
    end
    $display("Summary: %0d check failures, %0d results compared", errors, checked);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

/* compile.f */
hdl/mv_pkg.sv
hdl/mv_mac_lane.sv
hdl/mv_transpose_buf.sv
hdl/mv_feeder.sv
hdl/mv_drain.sv
hdl/mv_top.sv
test/tb_mv_top.sv

/* Makefile */
TOP = tb_mv_top
LOG = sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f compile.f --top-module $(TOP) \
		-Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "No errors" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
